// File: rtl/uart_line_pkg.sv
/*
 * Serial line constants: 8N1 on receive, two stop bits on transmit.
 * bit_clks rounds to the nearest whole clock. Keep CLK_FREQ / BAUD_RATE
 * at 4 or more so the bit centre and bit end fall on different counts.
 */
`default_nettype none

package uart_line_pkg;

	localparam int DATA_BITS = 8;

	// extra stop bit gives the far end some slack
	localparam int TX_STOP_BITS = 2;

	// sys_clk cycles per bit, rounded
	function automatic int bit_clks(input int clk_freq, input int baud_rate);
		return (clk_freq + baud_rate / 2) / baud_rate;
	endfunction

endpackage

`default_nettype wire

// File: rtl/uart_frame_pkg.sv
/*
 * String framing definitions: "&&" content "&&", no escaping.
 * Lengths are 8 bits wide, so MAX_LEN must stay at 255 or below.
 */
`default_nettype none

package uart_frame_pkg;

	// ampersand
	localparam logic [7:0] DELIM_CHAR = 8'h26;

	// delimiters at each end of a frame
	localparam int DELIM_COUNT = 2;

	// shared by the transmit and receive machines
	typedef enum logic [2:0] {
		FR_IDLE,
		FR_OPEN,
		FR_CONTENT,
		FR_CLOSE,
		FR_FINISH
	} frame_state_t;

	typedef logic [7:0] len_t;

endpackage

`default_nettype wire

// File: rtl/uart_byte_if.sv
/*
 * Byte-level link between the framing controller and the serial modules.
 * All strobes are single-cycle pulses. rx_data is only meaningful with rx_vld.
 */
`timescale 1ns/1ps
`default_nettype none

interface uart_byte_if;

	// controller to serializer
	logic [7:0] tx_data;
	logic       tx_req;
	logic       tx_done;

	// deserializer to controller
	logic [7:0] rx_data;
	logic       rx_vld;
	logic       rx_err;

	modport ctrl (output tx_data, output tx_req, input tx_done,
		input rx_data, input rx_vld, input rx_err);

	modport tx_side (input tx_data, input tx_req, output tx_done);

	modport rx_side (output rx_data, output rx_vld, output rx_err);

endinterface

`default_nettype wire

// File: rtl/bit_timer.sv
/*
 * Bit-period counter for one serial direction.
 * Held at zero while run is low, so the first period starts with run.
 * Ticks are combinational and only appear while run is high.
 */
`timescale 1ns/1ps
`default_nettype none

module bit_timer #(
	parameter int CLK_FREQ  = 50_000_000,
	parameter int BAUD_RATE = 115_200
) (
	input  wire  sys_clk,
	input  wire  sys_rst_n,
	input  logic run,
	output logic mid_tick,
	output logic end_tick
);

	import uart_line_pkg::*;

	localparam int PERIOD = bit_clks(CLK_FREQ, BAUD_RATE);
	localparam int CNT_W  = $clog2(PERIOD);

	localparam logic [CNT_W-1:0] MID_CNT  = CNT_W'(PERIOD / 2);
	localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(PERIOD - 1);

	logic [CNT_W-1:0] cnt;

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			cnt <= '0;
		end else if (!run) begin
			cnt <= '0;
		end else if (cnt == LAST_CNT) begin
			cnt <= '0;
		end else begin
			cnt <= cnt + 1'b1;
		end
	end

	// centre tick is where the receiver samples
	assign mid_tick = run && (cnt == MID_CNT);
	assign end_tick = run && (cnt == LAST_CNT);

endmodule

`default_nettype wire

// File: rtl/uart_tx.sv
/*
 * Byte serializer: start bit, data LSB first, TX_STOP_BITS stop bits.
 * A request while a character is in progress is ignored.
 * tx_done comes one cycle after the last stop bit ends.
 */
`timescale 1ns/1ps
`default_nettype none

module uart_tx (
	input  wire  sys_clk,
	input  wire  sys_rst_n,
	uart_byte_if.tx_side bus,
	output logic run,
	input  logic end_tick,
	output logic tx
);

	import uart_line_pkg::*;

	localparam int FRAME_BITS = 1 + DATA_BITS + TX_STOP_BITS;
	localparam int CNT_W      = $clog2(FRAME_BITS);

	localparam logic [CNT_W-1:0] LAST_BIT = CNT_W'(FRAME_BITS - 1);

	logic [CNT_W-1:0]                  bit_cnt;
	logic [DATA_BITS+TX_STOP_BITS-1:0] shreg;

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			run         <= 1'b0;
			tx          <= 1'b1;
			bit_cnt     <= '0;
			bus.tx_done <= 1'b0;
		end else begin
			bus.tx_done <= 1'b0;
			if (!run) begin
				if (bus.tx_req) begin
					// start bit goes out straight away
					run     <= 1'b1;
					tx      <= 1'b0;
					bit_cnt <= '0;
				end
			end else if (end_tick) begin
				if (bit_cnt == LAST_BIT) begin
					run         <= 1'b0;
					tx          <= 1'b1;
					bus.tx_done <= 1'b1;
				end else begin
					tx      <= shreg[0];
					bit_cnt <= bit_cnt + 1'b1;
				end
			end
		end
	end

	// data then stop bits, ones shift in behind
	always_ff @(posedge sys_clk) begin
		if (!run && bus.tx_req) begin
			shreg <= {{TX_STOP_BITS{1'b1}}, bus.tx_data};
		end else if (run && end_tick) begin
			shreg <= {1'b1, shreg[DATA_BITS+TX_STOP_BITS-1:1]};
		end
	end

endmodule

`default_nettype wire

// File: rtl/uart_rx.sv
/*
 * Byte deserializer, 8N1. Samples at bit centres after a 2-flop synchronizer.
 * A start bit that is high again at its centre is taken as a glitch.
 * A stop bit of one period or longer is accepted; a low stop bit gives rx_err.
 */
`timescale 1ns/1ps
`default_nettype none

module uart_rx (
	input  wire  sys_clk,
	input  wire  sys_rst_n,
	uart_byte_if.rx_side bus,
	output logic run,
	input  logic mid_tick,
	input  logic rx
);

	import uart_line_pkg::*;

	localparam int CNT_W = $clog2(DATA_BITS + 2);

	// bit 0 is the start bit, the stop bit follows the data
	localparam logic [CNT_W-1:0] STOP_BIT = CNT_W'(DATA_BITS + 1);

	logic                 rx_meta;
	logic                 rx_sync;
	logic                 rx_prev;
	logic [CNT_W-1:0]     bit_cnt;
	logic [DATA_BITS-1:0] shreg;

	// idle line is high
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
			rx_prev <= 1'b1;
		end else begin
			rx_meta <= rx;
			rx_sync <= rx_meta;
			rx_prev <= rx_sync;
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			run        <= 1'b0;
			bit_cnt    <= '0;
			bus.rx_vld <= 1'b0;
			bus.rx_err <= 1'b0;
		end else begin
			bus.rx_vld <= 1'b0;
			bus.rx_err <= 1'b0;
			if (!run) begin
				// falling edge starts a character
				if (rx_prev && !rx_sync) begin
					run     <= 1'b1;
					bit_cnt <= '0;
				end
			end else if (mid_tick) begin
				if (bit_cnt == '0 && rx_sync) begin
					run <= 1'b0;
				end else if (bit_cnt == STOP_BIT) begin
					run        <= 1'b0;
					bus.rx_vld <= rx_sync;
					bus.rx_err <= !rx_sync;
				end else begin
					bit_cnt <= bit_cnt + 1'b1;
				end
			end
		end
	end

	// LSB arrives first
	always_ff @(posedge sys_clk) begin
		if (run && mid_tick && bit_cnt != '0 && bit_cnt != STOP_BIT) begin
			shreg <= {rx_sync, shreg[DATA_BITS-1:1]};
		end
	end

	assign bus.rx_data = shreg;

endmodule

`default_nettype wire

// File: rtl/string_frame_ctrl.sv
/*
 * Framing for strings sent as "&&" content "&&". tx_length above MAX_LEN is
 * clamped. Empty strings are not delivered: a delimiter right after the
 * opening pair restarts the hunt. Dropped frames: rx_err, overflow past
 * MAX_LEN, or a lone delimiter followed by another byte.
 */
`timescale 1ns/1ps
`default_nettype none

module string_frame_ctrl #(
	parameter int MAX_LEN = 32
) (
	input  wire                   sys_clk,
	input  wire                   sys_rst_n,
	input  logic [MAX_LEN*8-1:0]  tx_string,
	input  uart_frame_pkg::len_t  tx_length,
	input  logic                  tx_req,
	output logic                  tx_busy,
	output logic                  tx_done,
	output logic [MAX_LEN*8-1:0]  rx_string,
	output uart_frame_pkg::len_t  rx_length,
	output logic                  rx_busy,
	output logic                  rx_done,
	uart_byte_if.ctrl             bus
);

	import uart_frame_pkg::*;

	localparam logic [1:0] DCNT_LAST = 2'(DELIM_COUNT - 1);
	localparam len_t       LEN_MAX   = len_t'(MAX_LEN);

	frame_state_t         tx_state;
	logic [1:0]           tx_dcnt;
	len_t                 tx_cnt;
	len_t                 tx_len;
	logic [MAX_LEN*8-1:0] tx_buf;

	frame_state_t         rx_state;
	logic [1:0]           rx_dcnt;
	len_t                 rx_cnt;
	logic [MAX_LEN*8-1:0] rx_buf;
	logic                 rx_is_delim;
	logic                 rx_open_done;
	logic                 rx_store;
	logic                 tx_accept;

	// a new string can be taken in the finish cycle as well
	assign tx_accept = tx_req && (tx_state == FR_IDLE || tx_state == FR_FINISH);

	always_ff @(posedge sys_clk) begin
		if (tx_accept) begin
			tx_buf <= tx_string;
			tx_len <= (tx_length > LEN_MAX) ? LEN_MAX : tx_length;
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			tx_state    <= FR_IDLE;
			tx_dcnt     <= '0;
			tx_cnt      <= '0;
			bus.tx_req  <= 1'b0;
			bus.tx_data <= '0;
		end else begin
			bus.tx_req <= 1'b0;
			case (tx_state)
				FR_IDLE, FR_FINISH: begin
					tx_state <= FR_IDLE;
					if (tx_accept) begin
						tx_state    <= FR_OPEN;
						tx_dcnt     <= '0;
						bus.tx_req  <= 1'b1;
						bus.tx_data <= DELIM_CHAR;
					end
				end
				FR_OPEN: if (bus.tx_done) begin
					bus.tx_req <= 1'b1;
					if (tx_dcnt != DCNT_LAST) begin
						tx_dcnt     <= tx_dcnt + 1'b1;
						bus.tx_data <= DELIM_CHAR;
					end else if (tx_len == '0) begin
						tx_state    <= FR_CLOSE;
						tx_dcnt     <= '0;
						bus.tx_data <= DELIM_CHAR;
					end else begin
						tx_state    <= FR_CONTENT;
						tx_cnt      <= len_t'(1);
						bus.tx_data <= tx_buf[7:0];
					end
				end
				FR_CONTENT: if (bus.tx_done) begin
					bus.tx_req <= 1'b1;
					if (tx_cnt == tx_len) begin
						tx_state    <= FR_CLOSE;
						tx_dcnt     <= '0;
						bus.tx_data <= DELIM_CHAR;
					end else begin
						tx_cnt      <= tx_cnt + 1'b1;
						bus.tx_data <= tx_buf[tx_cnt*8 +: 8];
					end
				end
				FR_CLOSE: if (bus.tx_done) begin
					if (tx_dcnt == DCNT_LAST) begin
						tx_state <= FR_FINISH;
					end else begin
						tx_dcnt     <= tx_dcnt + 1'b1;
						bus.tx_req  <= 1'b1;
						bus.tx_data <= DELIM_CHAR;
					end
				end
				default: tx_state <= FR_IDLE;
			endcase
		end
	end

	assign tx_busy = (tx_state != FR_IDLE) && (tx_state != FR_FINISH);
	assign tx_done = (tx_state == FR_FINISH);

	assign rx_is_delim  = (bus.rx_data == DELIM_CHAR);
	assign rx_open_done = (rx_state == FR_OPEN) && bus.rx_vld && rx_is_delim
		&& (rx_dcnt == DCNT_LAST);
	assign rx_store     = (rx_state == FR_CONTENT) && bus.rx_vld && !rx_is_delim
		&& (rx_cnt < LEN_MAX);

	// cleared at frame start so unused bytes read back as zero
	always_ff @(posedge sys_clk) begin
		if (rx_open_done) begin
			rx_buf <= '0;
		end else if (rx_store) begin
			rx_buf[rx_cnt*8 +: 8] <= bus.rx_data;
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			rx_state  <= FR_IDLE;
			rx_dcnt   <= '0;
			rx_cnt    <= '0;
			rx_string <= '0;
			rx_length <= '0;
		end else begin
			case (rx_state)
				FR_IDLE, FR_FINISH: begin
					rx_state <= FR_IDLE;
					if (bus.rx_vld && rx_is_delim) begin
						rx_state <= FR_OPEN;
						rx_dcnt  <= 2'd1;
					end
				end
				FR_OPEN: begin
					if (bus.rx_err || (bus.rx_vld && !rx_is_delim)) begin
						rx_state <= FR_IDLE;
					end else if (rx_open_done) begin
						rx_state <= FR_CONTENT;
						rx_cnt   <= '0;
					end else if (bus.rx_vld) begin
						rx_dcnt <= rx_dcnt + 1'b1;
					end
				end
				FR_CONTENT: begin
					if (bus.rx_err) begin
						rx_state <= FR_IDLE;
					end else if (bus.rx_vld && rx_is_delim) begin
						// nothing stored yet: treat as a new opening run
						rx_state <= (rx_cnt == '0) ? FR_OPEN : FR_CLOSE;
						rx_dcnt  <= 2'd1;
					end else if (bus.rx_vld) begin
						if (rx_store) begin
							rx_cnt <= rx_cnt + 1'b1;
						end else begin
							rx_state <= FR_IDLE;
						end
					end
				end
				FR_CLOSE: begin
					if (bus.rx_err || (bus.rx_vld && !rx_is_delim)) begin
						rx_state <= FR_IDLE;
					end else if (bus.rx_vld && rx_dcnt == DCNT_LAST) begin
						// publish with the last delimiter, rx_done follows
						rx_state  <= FR_FINISH;
						rx_string <= rx_buf;
						rx_length <= rx_cnt;
					end else if (bus.rx_vld) begin
						rx_dcnt <= rx_dcnt + 1'b1;
					end
				end
				default: rx_state <= FR_IDLE;
			endcase
		end
	end

	assign rx_busy = (rx_state == FR_OPEN) || (rx_state == FR_CONTENT)
		|| (rx_state == FR_CLOSE);
	assign rx_done = (rx_state == FR_FINISH);

endmodule

`default_nettype wire

// File: rtl/uart_string_top.sv
/*
 * UART string transceiver. Strings are packed with byte 0 in the low bits.
 * Line format: 8 data bits, no parity; two stop bits out, one or more in.
 * No flow control: tx_req while tx_busy is dropped.
 */
`timescale 1ns/1ps
`default_nettype none

module uart_string_top #(
	parameter int CLK_FREQ  = 50_000_000,
	parameter int BAUD_RATE = 115_200,
	parameter int MAX_LEN   = 32
) (
	input  wire                   sys_clk,
	input  wire                   sys_rst_n,
	input  logic [MAX_LEN*8-1:0]  tx_string,
	input  uart_frame_pkg::len_t  tx_length,
	input  logic                  tx_req,
	output logic                  tx_busy,
	output logic                  tx_done,
	output logic [MAX_LEN*8-1:0]  rx_string,
	output uart_frame_pkg::len_t  rx_length,
	output logic                  rx_busy,
	output logic                  rx_done,
	input  logic                  uart_rx_port,
	output logic                  uart_tx_port
);

	logic tx_run;
	logic tx_end_tick;
	logic rx_run;
	logic rx_mid_tick;

	uart_byte_if u_byte_if ();

	string_frame_ctrl #(
		.MAX_LEN (MAX_LEN)
	) u_string_frame_ctrl (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.tx_string (tx_string),
		.tx_length (tx_length),
		.tx_req    (tx_req),
		.tx_busy   (tx_busy),
		.tx_done   (tx_done),
		.rx_string (rx_string),
		.rx_length (rx_length),
		.rx_busy   (rx_busy),
		.rx_done   (rx_done),
		.bus       (u_byte_if.ctrl)
	);

	uart_tx u_uart_tx (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.bus       (u_byte_if.tx_side),
		.run       (tx_run),
		.end_tick  (tx_end_tick),
		.tx        (uart_tx_port)
	);

	uart_rx u_uart_rx (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.bus       (u_byte_if.rx_side),
		.run       (rx_run),
		.mid_tick  (rx_mid_tick),
		.rx        (uart_rx_port)
	);

	// transmitter only steps on bit ends
	bit_timer #(
		.CLK_FREQ  (CLK_FREQ),
		.BAUD_RATE (BAUD_RATE)
	) u_tx_timer (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.run       (tx_run),
		.mid_tick  (),
		.end_tick  (tx_end_tick)
	);

	// receiver only samples at bit centres
	bit_timer #(
		.CLK_FREQ  (CLK_FREQ),
		.BAUD_RATE (BAUD_RATE)
	) u_rx_timer (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.run       (rx_run),
		.mid_tick  (rx_mid_tick),
		.end_tick  ()
	);

endmodule

`default_nettype wire

// File: tb/tb_uart_string_top.sv
/*
 * Directed testbench for the UART string transceiver at 10 clocks per bit.
 * uart_rx_port is looped back from uart_tx_port or driven by a line driver.
 * Strings are held as bytes in msg and packed with byte 0 in the low bits.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_uart_string_top;

	import uart_line_pkg::*;

	localparam int CLK_FREQ   = 50_000_000;
	localparam int BAUD_RATE  = 5_000_000;
	localparam int MAX_LEN    = 32;
	localparam int CLK_PERIOD = 20;
	localparam int BIT_CLKS   = bit_clks(CLK_FREQ, BAUD_RATE);
	localparam int BIT_NS     = BIT_CLKS * CLK_PERIOD;
	// whole run fits in eight frames of MAX_LEN + 5 bytes, doubled
	localparam int TIMEOUT_NS = 8 * (MAX_LEN + 5) * 11 * BIT_NS * 2 + 10_000;

	typedef logic [MAX_LEN*8-1:0] str_t;

	logic       sys_clk;
	logic       sys_rst_n;
	str_t       tx_string;
	logic [7:0] tx_length;
	logic       tx_req;
	logic       tx_busy;
	logic       tx_done;
	str_t       rx_string;
	logic [7:0] rx_length;
	logic       rx_busy;
	logic       rx_done;
	logic       uart_rx_port;
	logic       uart_tx_port;
	logic       loopback;
	logic       line_drv;

	int         errors;
	int         checks;
	int         tx_done_cnt;
	int         rx_done_cnt;
	int         stop_low_cnt;
	int         msg_len;
	logic [7:0] msg [0:63];
	logic [7:0] line_q [$];

	assign uart_rx_port = loopback ? uart_tx_port : line_drv;

	uart_string_top #(
		.CLK_FREQ  (CLK_FREQ),
		.BAUD_RATE (BAUD_RATE),
		.MAX_LEN   (MAX_LEN)
	) u_uart_string_top (
		.sys_clk      (sys_clk),
		.sys_rst_n    (sys_rst_n),
		.tx_string    (tx_string),
		.tx_length    (tx_length),
		.tx_req       (tx_req),
		.tx_busy      (tx_busy),
		.tx_done      (tx_done),
		.rx_string    (rx_string),
		.rx_length    (rx_length),
		.rx_busy      (rx_busy),
		.rx_done      (rx_done),
		.uart_rx_port (uart_rx_port),
		.uart_tx_port (uart_tx_port)
	);

	initial begin
		sys_clk = 1'b0;
		forever #(CLK_PERIOD / 2) sys_clk = ~sys_clk;
	end

	// done pulses are one cycle wide
	always @(posedge sys_clk) begin
		if (tx_done) begin
			tx_done_cnt <= tx_done_cnt + 1;
		end
		if (rx_done) begin
			rx_done_cnt <= rx_done_cnt + 1;
		end
	end

	// decodes uart_tx_port half a clock after each bit centre
	initial begin : tx_line_decoder
		logic [7:0] b;
		forever begin
			@(negedge uart_tx_port);
			#(BIT_NS + BIT_NS / 2 + CLK_PERIOD / 2);
			for (int i = 0; i < DATA_BITS; i++) begin
				b[i] = uart_tx_port;
				#(BIT_NS);
			end
			for (int i = 0; i < TX_STOP_BITS; i++) begin
				if (i > 0) begin
					#(BIT_NS);
				end
				if (!uart_tx_port) begin
					stop_low_cnt++;
				end
			end
			line_q.push_back(b);
		end
	end

	initial begin : watchdog
		#(TIMEOUT_NS);
		$display("error: run timed out after %0d ns", TIMEOUT_NS);
		$display("CHECKS FAILED");
		$finish;
	end

	task automatic check_value(input string name, input str_t exp, input str_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("error: %s expected %0h actual %0h", name, exp, act);
		end
	endtask

	function automatic str_t packed_msg(input int first, input int count);
		str_t v;
		v = '0;
		for (int i = 0; i < count && i < MAX_LEN; i++) begin
			v[i*8 +: 8] = msg[first + i];
		end
		return v;
	endfunction

	// generous cycle budget for one string, delimiters included
	function automatic int frame_cycles(input int len);
		return (len + 4) * 11 * BIT_CLKS * 2 + 100;
	endfunction

	task automatic load_text(input string s);
		msg_len = s.len();
		for (int i = 0; i < msg_len; i++) begin
			msg[i] = s[i];
		end
	endtask

	// content bytes never hold the delimiter
	task automatic load_random(input int first, input int count);
		logic [7:0] b;
		for (int i = 0; i < count; i++) begin
			b = 8'($urandom_range(255, 0));
			while (b == 8'h26) begin
				b = 8'($urandom_range(255, 0));
			end
			msg[first + i] = b;
		end
	endtask

	task automatic start_tx(input str_t str, input int len);
		@(negedge sys_clk);
		tx_string = str;
		tx_length = 8'(len);
		tx_req    = 1'b1;
		@(negedge sys_clk);
		tx_req = 1'b0;
	endtask

	task automatic wait_for_done(input bit on_rx, input int target, input int max_cycles,
		input string name);
		int n;
		n = 0;
		while ((on_rx ? rx_done_cnt : tx_done_cnt) < target && n < max_cycles) begin
			@(negedge sys_clk);
			n++;
		end
		if ((on_rx ? rx_done_cnt : tx_done_cnt) < target) begin
			errors++;
			$display("error: %s timed out waiting for %s", name, on_rx ? "rx_done" : "tx_done");
		end
	endtask

	task automatic drive_line_byte(input logic [7:0] b, input logic stop_bit);
		@(negedge sys_clk);
		line_drv = 1'b0;
		repeat (BIT_CLKS) @(negedge sys_clk);
		for (int i = 0; i < DATA_BITS; i++) begin
			line_drv = b[i];
			repeat (BIT_CLKS) @(negedge sys_clk);
		end
		line_drv = stop_bit;
		repeat (BIT_CLKS) @(negedge sys_clk);
		// idle bit, so a low stop bit is followed by a fresh falling edge
		line_drv = 1'b1;
		repeat (BIT_CLKS) @(negedge sys_clk);
	endtask

	task automatic drive_msg_bytes(input int first, input int count);
		for (int i = 0; i < count; i++) begin
			drive_line_byte(msg[first + i], 1'b1);
		end
	endtask

	task automatic loopback_check(input string name);
		int tx_start;
		int rx_start;
		tx_start = tx_done_cnt;
		rx_start = rx_done_cnt;
		start_tx(packed_msg(0, msg_len), msg_len);
		wait_for_done(1'b0, tx_start + 1, frame_cycles(msg_len), name);
		check_value({name, " rx_done count"}, str_t'(rx_start + 1), str_t'(rx_done_cnt));
		check_value({name, " rx_length"}, str_t'(msg_len), str_t'(rx_length));
		check_value({name, " rx_string"}, packed_msg(0, msg_len), rx_string);
	endtask

	task automatic idle_after_reset();
		check_value("idle tx_busy", '0, str_t'(tx_busy));
		check_value("idle tx_done", '0, str_t'(tx_done));
		check_value("idle rx_busy", '0, str_t'(rx_busy));
		check_value("idle rx_done", '0, str_t'(rx_done));
		check_value("idle uart_tx_port", str_t'(1), str_t'(uart_tx_port));
	endtask

	task automatic loopback_strings();
		load_text("hello");
		loopback_check("hello");
		repeat (3) begin
			msg_len = $urandom_range(MAX_LEN, 1);
			load_random(0, msg_len);
			loopback_check("random");
		end
	endtask

	task automatic tx_waveform();
		int tx_start;
		logic [7:0] exp;
		msg_len = 8;
		load_random(0, msg_len);
		line_q.delete();
		stop_low_cnt = 0;
		tx_start = tx_done_cnt;
		start_tx(packed_msg(0, msg_len), msg_len);
		wait_for_done(1'b0, tx_start + 1, frame_cycles(msg_len), "waveform");
		check_value("waveform byte count", str_t'(msg_len + 4), str_t'(line_q.size()));
		if (line_q.size() == msg_len + 4) begin
			for (int i = 0; i < msg_len + 4; i++) begin
				exp = (i < 2 || i >= msg_len + 2) ? 8'h26 : msg[i - 2];
				check_value("waveform byte", str_t'(exp), str_t'(line_q[i]));
			end
		end
		check_value("waveform low stop bits", '0, str_t'(stop_low_cnt));
	endtask

	task automatic busy_request();
		int tx_start;
		int rx_start;
		msg_len = 6;
		load_random(0, msg_len);
		tx_start = tx_done_cnt;
		rx_start = rx_done_cnt;
		start_tx(packed_msg(0, msg_len), msg_len);
		// land inside the third byte
		repeat (2 * 11 * BIT_CLKS + BIT_CLKS * 5) @(negedge sys_clk);
		check_value("busy tx_busy", str_t'(1), str_t'(tx_busy));
		start_tx({MAX_LEN{8'h5a}}, 3);
		wait_for_done(1'b0, tx_start + 1, frame_cycles(msg_len), "busy request");
		// a queued second string would be done well within this
		repeat (frame_cycles(3)) @(negedge sys_clk);
		check_value("busy tx_done count", str_t'(tx_start + 1), str_t'(tx_done_cnt));
		check_value("busy rx_done count", str_t'(rx_start + 1), str_t'(rx_done_cnt));
		check_value("busy rx_length", str_t'(msg_len), str_t'(rx_length));
		check_value("busy rx_string", packed_msg(0, msg_len), rx_string);
	endtask

	task automatic rx_error_recovery();
		int rx_start;
		loopback = 1'b0;
		rx_start = rx_done_cnt;
		load_text("&&ab");
		drive_msg_bytes(0, msg_len);
		drive_line_byte(8'h55, 1'b0);
		load_text("&&");
		drive_msg_bytes(0, msg_len);
		repeat (2 * 11 * BIT_CLKS) @(negedge sys_clk);
		check_value("rx error dropped", str_t'(rx_start), str_t'(rx_done_cnt));
		// the fresh opening pair leaves the receiver inside a frame
		check_value("rx error rx_busy", str_t'(1), str_t'(rx_busy));
		load_text("&&xyz&&");
		drive_msg_bytes(0, msg_len);
		wait_for_done(1'b1, rx_start + 1, frame_cycles(3), "rx error");
		check_value("rx error rx_length", str_t'(3), str_t'(rx_length));
		check_value("rx error rx_string", packed_msg(2, 3), rx_string);
		loopback = 1'b1;
	endtask

	task automatic overflow_drop();
		int rx_start;
		loopback = 1'b0;
		rx_start = rx_done_cnt;
		msg[0] = 8'h26;
		msg[1] = 8'h26;
		load_random(2, MAX_LEN + 1);
		msg[MAX_LEN + 3] = 8'h26;
		msg[MAX_LEN + 4] = 8'h26;
		msg_len = MAX_LEN + 5;
		drive_msg_bytes(0, msg_len);
		repeat (2 * 11 * BIT_CLKS) @(negedge sys_clk);
		check_value("overflow dropped", str_t'(rx_start), str_t'(rx_done_cnt));
		loopback = 1'b1;
		msg_len = $urandom_range(MAX_LEN, 1);
		load_random(0, msg_len);
		loopback_check("after overflow");
	endtask

	initial begin
		errors       = 0;
		checks       = 0;
		tx_done_cnt  = 0;
		rx_done_cnt  = 0;
		stop_low_cnt = 0;
		msg_len      = 0;
		void'($urandom(20));
		sys_rst_n    = 1'b0;
		tx_string    = '0;
		tx_length    = '0;
		tx_req       = 1'b0;
		loopback     = 1'b1;
		line_drv     = 1'b1;
		repeat (3) @(posedge sys_clk);
		@(negedge sys_clk);
		sys_rst_n = 1'b1;
		@(negedge sys_clk);

		idle_after_reset();
		loopback_strings();
		tx_waveform();
		busy_request();
		rx_error_recovery();
		overflow_drop();

		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: uart_string_top.f
rtl/uart_line_pkg.sv
rtl/uart_frame_pkg.sv
rtl/uart_byte_if.sv
rtl/bit_timer.sv
rtl/uart_tx.sv
rtl/uart_rx.sv
rtl/string_frame_ctrl.sv
rtl/uart_string_top.sv
tb/tb_uart_string_top.sv
